// File: verilog/rv_bus_pkg.sv
/*
 * Bus and register file widths shared by the core and its memory ports.
 */
package rv_bus_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Register file geometry
  localparam int unsigned NREGS  = 32;
  localparam int unsigned REG_AW = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

endpackage

// File: verilog/rv_isa_pkg.sv
/*
 * RV32I instruction set definitions: major opcodes, ALU operations,
 * instruction field positions and the funct3/funct7 values in use.
 */
package rv_isa_pkg;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  //////////////////////////////
  // ALU operations
  //////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_EQ,
    ALU_NE
  } alu_op_e;

  // Field positions (LSB of each field)
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned FUNCT3_LSB = 12;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned FUNCT7_LSB = 25;

  // funct3 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_ADDI    = 3'b000;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // funct7 values
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // ADDI x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// File: verilog/rv_core_ifs.sv
/*
 * Internal core interfaces: decode to ALU, and decode to load/store unit.
 */
`timescale 1ns/1ps

interface exec_if;
  import rv_bus_pkg::*;
  import rv_isa_pkg::*;

  alu_op_e alu_op;
  word_t   operand_a;
  word_t   operand_b;
  word_t   pc;
  word_t   imm;
  word_t   result;
  logic    branch_taken;
  word_t   jump_target;

  modport decode (output alu_op, operand_a, operand_b, pc, imm,
                  input  result, branch_taken, jump_target);
  modport alu    (input  alu_op, operand_a, operand_b, pc, imm,
                  output result, branch_taken, jump_target);
endinterface

interface lsu_if;
  import rv_bus_pkg::*;

  logic  req;
  logic  we;
  word_t addr;
  word_t wdata;
  logic  done;
  word_t rdata;

  modport decode (output req, we, addr, wdata, input  done, rdata);
  modport lsu    (input  req, we, addr, wdata, output done, rdata);
endinterface

// File: verilog/rv_fetch.sv
/*
 * Instruction fetch: holds the PC and runs one instruction-port
 * transaction at a time, then presents the word to decode.
 */
`timescale 1ns/1ps

module rv_fetch (
  input  logic              clk,
  input  logic              rst_ni,
  input  rv_bus_pkg::word_t boot_addr_i,
  input  logic              fetch_enable_i,
  // Instruction port
  output logic              instr_req_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  output rv_bus_pkg::word_t instr_addr_o,
  input  rv_bus_pkg::word_t instr_rdata_i,
  // To and from decode
  output logic              instr_valid_o,
  output rv_bus_pkg::word_t instr_o,
  output rv_bus_pkg::word_t pc_o,
  input  logic              retire_i,
  input  logic              next_pc_sel_i,
  input  rv_bus_pkg::word_t branch_target_i
);
  import rv_bus_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, WAIT, HOLD} fetch_state_e;

  fetch_state_e state_q;
  word_t        pc_q;
  word_t        instr_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      pc_q    <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (fetch_enable_i) begin
            pc_q    <= boot_addr_i;
            state_q <= REQ;
          end
        end
        REQ: begin
          if (instr_gnt_i) state_q <= WAIT;
        end
        WAIT: begin
          if (instr_rvalid_i) state_q <= HOLD;
        end
        HOLD: begin
          // Next PC is taken at retire, then the next request starts
          if (retire_i) begin
            pc_q    <= next_pc_sel_i ? branch_target_i : pc_q + word_t'(4);
            state_q <= REQ;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Instruction word captured with rvalid
  always_ff @(posedge clk) begin
    if (state_q == WAIT && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o   = (state_q == REQ);
  assign instr_addr_o  = pc_q;
  assign instr_valid_o = (state_q == HOLD);
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;

endmodule

// File: verilog/rv_decode.sv
/*
 * Decode and control: field split, immediates, operand selection,
 * load/store request, writeback mux and retire.
 */
`timescale 1ns/1ps

module rv_decode (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  logic                 instr_valid_i,
  input  rv_bus_pkg::word_t    instr_i,
  input  rv_bus_pkg::word_t    pc_i,
  input  rv_bus_pkg::word_t    rs1_data_i,
  input  rv_bus_pkg::word_t    rs2_data_i,
  output logic                 retire_o,
  output logic                 next_pc_sel_o,
  output rv_bus_pkg::word_t    branch_target_o,
  output rv_bus_pkg::reg_idx_t rs1_idx_o,
  output rv_bus_pkg::reg_idx_t rs2_idx_o,
  output rv_bus_pkg::reg_idx_t rd_idx_o,
  output logic                 rd_we_o,
  output rv_bus_pkg::word_t    rd_data_o,
  exec_if.decode               ex,
  lsu_if.decode                mem
);
  import rv_bus_pkg::*;
  import rv_isa_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t      link_addr;
  logic       is_load, is_store, is_jal, is_branch, writes_rd;
  logic       is_mem;
  logic       mem_done_q;

  //////////////////////////////
  // Fields and immediates
  //////////////////////////////
  assign opcode    = opcode_e'(instr_i[6:0]);
  assign funct3    = instr_i[FUNCT3_LSB +: 3];
  assign funct7    = instr_i[FUNCT7_LSB +: 7];
  assign rs1_idx_o = instr_i[RS1_LSB +: REG_AW];
  assign rs2_idx_o = instr_i[RS2_LSB +: REG_AW];
  assign rd_idx_o  = instr_i[RD_LSB +: REG_AW];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  //////////////////////////////
  // Decoder
  //////////////////////////////
  // Anything not matched falls through as a no-op
  always_comb begin
    ex.alu_op    = ALU_ADD;
    ex.operand_a = rs1_data_i;
    ex.operand_b = rs2_data_i;
    ex.imm       = imm_b;
    is_load      = 1'b0;
    is_store     = 1'b0;
    is_jal       = 1'b0;
    is_branch    = 1'b0;
    writes_rd    = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
          ex.alu_op = ALU_SUB;
          writes_rd = 1'b1;
        end else if (funct7 == F7_BASE) begin
          writes_rd = 1'b1;
          case (funct3)
            F3_ADD_SUB: ex.alu_op = ALU_ADD;
            F3_SLT:     ex.alu_op = ALU_SLT;
            F3_XOR:     ex.alu_op = ALU_XOR;
            F3_OR:      ex.alu_op = ALU_OR;
            F3_AND:     ex.alu_op = ALU_AND;
            default:    writes_rd = 1'b0;
          endcase
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == F3_ADDI) begin
          ex.operand_b = imm_i;
          writes_rd    = 1'b1;
        end
      end
      OPC_LUI: begin
        ex.operand_a = '0;
        ex.operand_b = imm_u;
        writes_rd    = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == F3_LW) begin
          ex.operand_b = imm_i;
          is_load      = 1'b1;
          writes_rd    = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_SW) begin
          ex.operand_b = imm_s;
          is_store     = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == F3_BEQ) begin
          ex.alu_op = ALU_EQ;
          is_branch = 1'b1;
        end else if (funct3 == F3_BNE) begin
          ex.alu_op = ALU_NE;
          is_branch = 1'b1;
        end
      end
      OPC_JAL: begin
        ex.imm    = imm_j;
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      default: ;
    endcase
  end

  assign ex.pc  = pc_i;
  assign is_mem = is_load | is_store;

  //////////////////////////////
  // Load/store request
  //////////////////////////////
  // Set once the access is done, so the same instruction never issues twice
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_done_q <= 1'b0;
    end else if (!instr_valid_i) begin
      mem_done_q <= 1'b0;
    end else if (mem.done) begin
      mem_done_q <= 1'b1;
    end
  end

  assign mem.req   = instr_valid_i & is_mem & ~mem_done_q;
  assign mem.we    = is_store;
  assign mem.addr  = ex.result;
  assign mem.wdata = rs2_data_i;

  //////////////////////////////
  // Retire and writeback
  //////////////////////////////
  assign retire_o        = instr_valid_i & (is_mem ? mem.done : 1'b1);
  assign next_pc_sel_o   = is_jal | (is_branch & ex.branch_taken);
  assign branch_target_o = ex.jump_target;

  assign link_addr = pc_i + word_t'(4);
  assign rd_data_o = is_load ? mem.rdata : (is_jal ? link_addr : ex.result);
  assign rd_we_o   = retire_o & writes_rd;

endmodule

// File: verilog/rv_regfile.sv
/*
 * Register file, 31 writable registers, x0 reads as zero.
 */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  rv_bus_pkg::reg_idx_t raddr_a_i,
  input  rv_bus_pkg::reg_idx_t raddr_b_i,
  input  rv_bus_pkg::reg_idx_t waddr_i,
  input  logic                 we_i,
  input  rv_bus_pkg::word_t    wdata_i,
  output rv_bus_pkg::word_t    rdata_a_o,
  output rv_bus_pkg::word_t    rdata_b_o
);
  import rv_bus_pkg::*;

  word_t regs_q [1:NREGS-1];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{default: '0};
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: verilog/rv_alu.sv
/*
 * ALU with compare, branch decision and the PC-relative target adder.
 */
`timescale 1ns/1ps

module rv_alu (
  exec_if.alu ex
);
  import rv_bus_pkg::*;
  import rv_isa_pkg::*;

  logic operands_equal;
  logic less_signed;

  assign operands_equal = (ex.operand_a == ex.operand_b);
  assign less_signed    = $signed(ex.operand_a) < $signed(ex.operand_b);

  always_comb begin
    ex.branch_taken = 1'b0;
    case (ex.alu_op)
      ALU_ADD: ex.result = ex.operand_a + ex.operand_b;
      ALU_SUB: ex.result = ex.operand_a - ex.operand_b;
      ALU_AND: ex.result = ex.operand_a & ex.operand_b;
      ALU_OR:  ex.result = ex.operand_a | ex.operand_b;
      ALU_XOR: ex.result = ex.operand_a ^ ex.operand_b;
      ALU_SLT: ex.result = {{(XLEN-1){1'b0}}, less_signed};
      ALU_EQ: begin
        ex.branch_taken = operands_equal;
        ex.result       = {{(XLEN-1){1'b0}}, operands_equal};
      end
      ALU_NE: begin
        ex.branch_taken = ~operands_equal;
        ex.result       = {{(XLEN-1){1'b0}}, ~operands_equal};
      end
      default: ex.result = '0;
    endcase
  end

  // Same adder serves branches and JAL
  assign ex.jump_target = ex.pc + ex.imm;

endmodule

// File: verilog/rv_lsu.sv
/*
 * Load/store unit: one word access at a time on the data port.
 */
`timescale 1ns/1ps

module rv_lsu (
  input  logic              clk,
  input  logic              rst_ni,
  // Data port
  output logic              data_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  output logic              data_we_o,
  output rv_bus_pkg::word_t data_addr_o,
  output rv_bus_pkg::word_t data_wdata_o,
  input  rv_bus_pkg::word_t data_rdata_i,
  // From decode
  lsu_if.lsu                mem
);

  typedef enum logic {IDLE, WAIT_RVALID} lsu_state_e;

  lsu_state_e state_q;
  logic       granted;

  assign granted = (state_q == IDLE) & mem.req & data_gnt_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          // Loads wait for the read data after grant
          if (granted && !mem.we) state_q <= WAIT_RVALID;
        end
        WAIT_RVALID: begin
          if (data_rvalid_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request follows decode directly, held by decode until grant
  assign data_req_o   = (state_q == IDLE) & mem.req;
  assign data_we_o    = mem.we;
  assign data_addr_o  = mem.addr;
  assign data_wdata_o = mem.wdata;

  // Store ends on grant, load ends on rvalid
  assign mem.done  = (granted & mem.we) | ((state_q == WAIT_RVALID) & data_rvalid_i);
  assign mem.rdata = data_rdata_i;

endmodule

// File: verilog/rv_core.sv
/*
 * RV32I core top level, fetch, decode, register file, ALU and LSU
 * joined to the instruction and data ports.
 */
`timescale 1ns/1ps

module rv_core (
  input  logic              clk,
  input  logic              rst_ni,
  input  rv_bus_pkg::word_t boot_addr_i,
  input  logic              fetch_enable_i,
  // Instruction port
  output logic              instr_req_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  output rv_bus_pkg::word_t instr_addr_o,
  input  rv_bus_pkg::word_t instr_rdata_i,
  // Data port
  output logic              data_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  output logic              data_we_o,
  output rv_bus_pkg::word_t data_addr_o,
  output rv_bus_pkg::word_t data_wdata_o,
  input  rv_bus_pkg::word_t data_rdata_i
);
  import rv_bus_pkg::*;

  logic     instr_valid, retire, next_pc_sel, rd_we;
  word_t    instr, pc, branch_target;
  word_t    rs1_data, rs2_data, rd_data;
  reg_idx_t rs1_idx, rs2_idx, rd_idx;

  exec_if u_exec_if ();
  lsu_if  u_lsu_if ();

  //////////////////////////////
  // Fetch
  //////////////////////////////
  rv_fetch u_fetch (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .boot_addr_i     (boot_addr_i),
    .fetch_enable_i  (fetch_enable_i),
    .instr_req_o     (instr_req_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_addr_o    (instr_addr_o),
    .instr_rdata_i   (instr_rdata_i),
    .instr_valid_o   (instr_valid),
    .instr_o         (instr),
    .pc_o            (pc),
    .retire_i        (retire),
    .next_pc_sel_i   (next_pc_sel),
    .branch_target_i (branch_target)
  );

  //////////////////////////////
  // Decode and execute
  //////////////////////////////
  rv_decode u_decode (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .instr_valid_i   (instr_valid),
    .instr_i         (instr),
    .pc_i            (pc),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .retire_o        (retire),
    .next_pc_sel_o   (next_pc_sel),
    .branch_target_o (branch_target),
    .rs1_idx_o       (rs1_idx),
    .rs2_idx_o       (rs2_idx),
    .rd_idx_o        (rd_idx),
    .rd_we_o         (rd_we),
    .rd_data_o       (rd_data),
    .ex              (u_exec_if.decode),
    .mem             (u_lsu_if.decode)
  );

  rv_regfile u_regfile (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_idx),
    .raddr_b_i (rs2_idx),
    .waddr_i   (rd_idx),
    .we_i      (rd_we),
    .wdata_i   (rd_data),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  rv_alu u_alu (
    .ex (u_exec_if.alu)
  );

  //////////////////////////////
  // Load/store
  //////////////////////////////
  rv_lsu u_lsu (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i),
    .mem           (u_lsu_if.lsu)
  );

endmodule

// File: tb/rv_core_asserts.sv
/*
 * Bus protocol assertions for both memory ports of the core.
 */
`timescale 1ns/1ps

module rv_core_asserts (
  input logic              clk,
  input logic              rst_ni,
  input logic              instr_req_o,
  input logic              instr_gnt_i,
  input logic              instr_rvalid_i,
  input rv_bus_pkg::word_t instr_addr_o,
  input logic              data_req_o,
  input logic              data_gnt_i,
  input logic              data_rvalid_i,
  input logic              data_we_o,
  input rv_bus_pkg::word_t data_addr_o,
  input rv_bus_pkg::word_t data_wdata_o
);

  logic instr_pend_q;
  logic data_pend_q;

  // Reads granted but not yet answered
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_pend_q <= 1'b0;
      data_pend_q  <= 1'b0;
    end else begin
      if (instr_req_o && instr_gnt_i) instr_pend_q <= 1'b1;
      else if (instr_rvalid_i) instr_pend_q <= 1'b0;
      if (data_req_o && data_gnt_i && !data_we_o) data_pend_q <= 1'b1;
      else if (data_rvalid_i) data_pend_q <= 1'b0;
    end
  end

  instr_stable_a: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request changed before grant");

  data_stable_a: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_we_o) &&
      $stable(data_addr_o) && $stable(data_wdata_o))
    else $error("data request changed before grant");

  instr_pending_a: assert property (@(posedge clk) disable iff (!rst_ni)
    !(instr_pend_q && instr_req_o))
    else $error("instruction request while a read is pending");

  data_pending_a: assert property (@(posedge clk) disable iff (!rst_ni)
    !(data_pend_q && data_req_o))
    else $error("data request while a read is pending");

endmodule

bind rv_core rv_core_asserts u_asserts (.*);

// File: tb/rv_core_tb.sv
/*
 * Testbench for the RV32I core: random program, bus memory models with
 * random delays, reference model and checks on fetches and stores.
 */
`timescale 1ns/1ps

module rv_core_tb #(
  parameter int unsigned SEED           = 80,
  parameter int unsigned TIMEOUT_CYCLES = 20000
);
  import rv_bus_pkg::*;
  import rv_isa_pkg::*;

  localparam word_t BOOT_ADDR = 32'h0000_0080;
  localparam int PROG_LEN = 96;
  localparam int DUMP_IDX = 80;
  localparam int END_IDX  = 95;
  localparam int DMEM_WORDS = 1024;

  // Instruction kinds of the generator
  localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_XOR = 4, K_SLT = 5;
  localparam int K_ADDI = 6, K_LUI = 7, K_LW = 8, K_SW = 9;
  localparam int K_BEQ = 10, K_BNE = 11, K_JAL = 12;

  logic  clk, rst_ni, fetch_enable_i;
  word_t boot_addr_i;
  logic  instr_req_o, instr_gnt_i, instr_rvalid_i;
  word_t instr_addr_o, instr_rdata_i;
  logic  data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  word_t data_addr_o, data_wdata_o, data_rdata_i;

  int       kind [PROG_LEN];
  reg_idx_t rd_f [PROG_LEN];
  reg_idx_t rs1_f [PROG_LEN];
  reg_idx_t rs2_f [PROG_LEN];
  word_t    imm_f [PROG_LEN];
  word_t    imem [PROG_LEN];
  word_t    dmem_dut [DMEM_WORDS];
  word_t    dmem_ref [DMEM_WORDS];
  word_t    pc_trace [$];
  word_t    st_addr [$];
  word_t    st_data [$];
  int       trace_idx, store_idx, loop_hits;
  logic [31:0] prog_lfsr, imem_lfsr, dmem_lfsr;

  rv_core dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, inout logic [31:0] st, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);
      r  = {r[30:0], st[0]};
    end
  endtask

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "check failed");
    end
  endtask

  function automatic word_t fill_word(input word_t addr);
    return {addr[15:0] ^ 16'hA5C3, ~addr[15:0]} ^ (addr << 7);
  endfunction

  function automatic word_t encode(input int k, input reg_idx_t rd, input reg_idx_t rs1,
                                   input reg_idx_t rs2, input word_t imm);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (k == K_SUB) ? F7_SUB : F7_BASE;
    case (k)
      K_AND:   f3 = F3_AND;
      K_OR:    f3 = F3_OR;
      K_XOR:   f3 = F3_XOR;
      K_SLT:   f3 = F3_SLT;
      K_BNE:   f3 = F3_BNE;
      default: f3 = F3_ADD_SUB;
    endcase
    case (k)
      K_ADDI:       return {imm[11:0], rs1, F3_ADDI, rd, OPC_OP_IMM};
      K_LUI:        return {imm[31:12], rd, OPC_LUI};
      K_LW:         return {imm[11:0], rs1, F3_LW, rd, OPC_LOAD};
      K_SW:         return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
      K_BEQ, K_BNE: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
      K_JAL:        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
      default:      return {f7, rs2, rs1, f3, rd, OPC_OP};
    endcase
  endfunction

  //////////////////////////////
  // Program and reference model
  //////////////////////////////
  task automatic gen_program();
    logic [31:0] r;
    int off;
    for (int i = 0; i < DUMP_IDX; i++) begin
      take_bits(4, prog_lfsr, r);
      kind[i] = (r < 13) ? int'(r) : (r == 13 ? K_ADDI : (r == 14 ? K_LW : K_SW));
      take_bits(4, prog_lfsr, r);
      rd_f[i] = (r[3:0] == 0) ? reg_idx_t'(1) : reg_idx_t'(r[3:0]);
      take_bits(4, prog_lfsr, r);
      rs1_f[i] = reg_idx_t'(r[3:0]);
      take_bits(4, prog_lfsr, r);
      rs2_f[i] = reg_idx_t'(r[3:0]);
      imm_f[i] = '0;
      case (kind[i])
        K_ADDI: begin
          take_bits(12, prog_lfsr, r);
          imm_f[i] = {{20{r[11]}}, r[11:0]};
        end
        K_LUI: begin
          take_bits(20, prog_lfsr, r);
          imm_f[i] = {r[19:0], 12'b0};
        end
        K_LW, K_SW: begin
          take_bits(6, prog_lfsr, r);
          imm_f[i] = 32'h400 + {24'b0, r[5:0], 2'b00};
          rs1_f[i] = '0;
        end
        K_BEQ, K_BNE, K_JAL: begin
          // Forward only, never past the register dump
          take_bits(3, prog_lfsr, r);
          off = int'(r) + 1;
          if (i + off > DUMP_IDX) off = DUMP_IDX - i;
          imm_f[i] = word_t'(off * 4);
        end
        default: ;
      endcase
    end
    for (int n = 1; n < 16; n++) begin
      kind[DUMP_IDX+n-1]  = K_SW;
      rd_f[DUMP_IDX+n-1]  = '0;
      rs1_f[DUMP_IDX+n-1] = '0;
      rs2_f[DUMP_IDX+n-1] = reg_idx_t'(n);
      imm_f[DUMP_IDX+n-1] = 32'h600 + word_t'(4 * (n - 1));
    end
    kind[END_IDX]  = K_JAL;
    rd_f[END_IDX]  = '0;
    rs1_f[END_IDX] = '0;
    rs2_f[END_IDX] = '0;
    imm_f[END_IDX] = '0;
    for (int i = 0; i < PROG_LEN; i++) begin
      imem[i] = encode(kind[i], rd_f[i], rs1_f[i], rs2_f[i], imm_f[i]);
    end
  endtask

  task automatic run_model();
    word_t regs [16];
    word_t a, b, res, pc, addr;
    int idx, next;
    logic wr;
    foreach (regs[n]) regs[n] = '0;
    idx = 0;
    forever begin
      pc = BOOT_ADDR + word_t'(idx * 4);
      pc_trace.push_back(pc);
      if (idx == END_IDX) break;
      a    = regs[rs1_f[idx]];
      b    = regs[rs2_f[idx]];
      addr = a + imm_f[idx];
      next = idx + 1;
      wr   = 1'b1;
      res  = '0;
      case (kind[idx])
        K_ADD:  res = a + b;
        K_SUB:  res = a - b;
        K_AND:  res = a & b;
        K_OR:   res = a | b;
        K_XOR:  res = a ^ b;
        K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        K_ADDI: res = addr;
        K_LUI:  res = imm_f[idx];
        K_LW:   res = dmem_ref[addr[11:2]];
        K_SW: begin
          wr = 1'b0;
          dmem_ref[addr[11:2]] = b;
          st_addr.push_back(addr);
          st_data.push_back(b);
        end
        K_BEQ, K_BNE: begin
          wr = 1'b0;
          if ((a == b) == (kind[idx] == K_BEQ)) next = idx + int'(imm_f[idx] >> 2);
        end
        default: begin
          res  = pc + 32'd4;
          next = idx + int'(imm_f[idx] >> 2);
        end
      endcase
      if (wr && rd_f[idx] != 0) regs[rd_f[idx]] = res;
      idx = next;
    end
  endtask

  function automatic word_t imem_read(input word_t addr);
    word_t offs;
    offs = (addr - BOOT_ADDR) >> 2;
    if (addr >= BOOT_ADDR && offs < PROG_LEN) return imem[offs];
    return NOP_INSTR;
  endfunction

  task automatic record_fetch(input word_t addr);
    if (trace_idx == 0) check_value("boot fetch address", addr, boot_addr_i);
    if (trace_idx < pc_trace.size()) begin
      check_value("fetch address", addr, pc_trace[trace_idx]);
      trace_idx++;
    end else begin
      check_value("final loop fetch", addr, pc_trace[pc_trace.size()-1]);
      loop_hits++;
    end
  endtask

  //////////////////////////////
  // Memory models
  //////////////////////////////
  initial begin : instr_responder
    word_t addr;
    logic [31:0] r;
    forever begin
      @(posedge clk);
      #1;
      if (rst_ni && instr_req_o) begin
        take_bits(2, imem_lfsr, r);
        repeat (r) begin
          @(posedge clk);
          #1;
        end
        addr = instr_addr_o;
        instr_gnt_i = 1'b1;
        record_fetch(addr);
        @(posedge clk);
        #1;
        instr_gnt_i = 1'b0;
        take_bits(2, imem_lfsr, r);
        if (r == 3) r = 2;
        repeat (r) begin
          @(posedge clk);
          #1;
        end
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = imem_read(addr);
        @(posedge clk);
        #1;
        instr_rvalid_i = 1'b0;
      end
    end
  end

  initial begin : data_responder
    word_t addr, wdata;
    logic we;
    logic [31:0] r;
    forever begin
      @(posedge clk);
      #1;
      if (rst_ni && data_req_o) begin
        take_bits(2, dmem_lfsr, r);
        repeat (r) begin
          @(posedge clk);
          #1;
        end
        we    = data_we_o;
        addr  = data_addr_o;
        wdata = data_wdata_o;
        data_gnt_i = 1'b1;
        if (we) begin
          check_value("store within expected count", word_t'(store_idx < st_addr.size()), 1);
          check_value("store address", addr, st_addr[store_idx]);
          check_value("store data", wdata, st_data[store_idx]);
          dmem_dut[addr[11:2]] = wdata;
          store_idx++;
        end
        @(posedge clk);
        #1;
        data_gnt_i = 1'b0;
        if (!we) begin
          take_bits(2, dmem_lfsr, r);
          if (r == 3) r = 2;
          repeat (r) begin
            @(posedge clk);
            #1;
          end
          data_rvalid_i = 1'b1;
          data_rdata_i  = dmem_dut[addr[11:2]];
          @(posedge clk);
          #1;
          data_rvalid_i = 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin : main
    int cycles;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    trace_idx = 0;
    store_idx = 0;
    loop_hits = 0;
    prog_lfsr = SEED;
    imem_lfsr = SEED ^ 32'h0000_1357;
    dmem_lfsr = SEED ^ 32'h0000_2468;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem_dut[i] = fill_word(word_t'(i * 4));
      dmem_ref[i] = dmem_dut[i];
    end
    gen_program();
    run_model();

    repeat (8) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    @(posedge clk);
    #1;
    fetch_enable_i = 1'b1;

    cycles = 0;
    while (loop_hits == 0 && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (loop_hits == 0) begin
      $display("Timeout: the program never reached its final jump loop");
      $display("Finished with errors");
      $fatal(1, "timeout");
    end else begin
      check_value("store count", word_t'(store_idx), word_t'(st_addr.size()));
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: rv_core.f
verilog/rv_bus_pkg.sv
verilog/rv_isa_pkg.sv
verilog/rv_core_ifs.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

// File: Makefile
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
SEED      ?= 80
TIMEOUT   ?= 20000
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
TOP       := rv_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail on errors in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR SEED TIMEOUT BUILD_DIR LOG"

test:
	$(VERILATOR) --binary --timing --assert -f rv_core.f --top-module $(TOP) \
		-GSEED=$(SEED) -GTIMEOUT_CYCLES=$(TIMEOUT) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
